/* hw/commit_trace_settings.svh */
`ifndef COMMIT_TRACE_SETTINGS_SVH
`define COMMIT_TRACE_SETTINGS_SVH

// commit ports, the merge is built for two
`define CT_NR_COMMIT_PORTS 2

// cause and trap value width
`define CT_XLEN 64

// virtual address width of a pc
`define CT_VLEN 40

// entries in each retired-pc queue
`define CT_PC_QUEUE_DEPTH 8

`endif

/* hw/commit_trace_pkg.sv */
`include "commit_trace_settings.svh"

package commit_trace_pkg;

  // ----------------------------------------------------------------------
  // basic words
  // ----------------------------------------------------------------------

  typedef logic [`CT_VLEN-1:0] pc_t;
  typedef logic [`CT_XLEN-1:0] xlen_t;

  // encoding follows the riscv privileged spec
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // ----------------------------------------------------------------------
  // cause word
  // ----------------------------------------------------------------------

  // split view of mcause/scause
  typedef struct packed {
    logic                irq;
    logic [`CT_XLEN-2:0] code;
  } cause_fields_t;

  // raw word for the trace port, split view for classification
  typedef union packed {
    xlen_t         raw;
    cause_fields_t fields;
  } cause_t;

  // ----------------------------------------------------------------------
  // commit side
  // ----------------------------------------------------------------------

  // one entry as presented by the scoreboard at commit
  typedef struct packed {
    pc_t    pc;
    logic   ex_valid;
    cause_t cause;
    xlen_t  tval;
  } commit_entry_t;

  // per-port trace record
  // insn is taken from the low half of tval, as the decoder leaves
  // the instruction word there for every committed entry
  typedef struct packed {
    logic        valid;
    logic [31:0] insn;
    pc_t         iaddr;
    priv_lvl_t   priv;
    logic        exception;
    logic        interrupt;
    cause_t      cause;
    xlen_t       tval;
  } trace_port_t;

  // ----------------------------------------------------------------------
  // merged retire stream
  // ----------------------------------------------------------------------

  typedef struct packed {
    pc_t                                   pc;
    logic [$clog2(`CT_NR_COMMIT_PORTS)-1:0] port;
  } merged_pc_t;

endpackage

/* hw/commit_port_tracer.sv */
`timescale 1ns/1ps
`include "commit_trace_settings.svh"

module commit_port_tracer #(
  parameter int unsigned Depth = `CT_PC_QUEUE_DEPTH
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            commit_ack_i,
  input  commit_trace_pkg::commit_entry_t commit_instr_i,
  input  commit_trace_pkg::priv_lvl_t     priv_lvl_i,
  input  logic                            pop_i,
  output commit_trace_pkg::trace_port_t   trace_o,
  output logic                            pc_avail_o,
  output commit_trace_pkg::pc_t           pc_head_o,
  output logic                            overflow_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  // ----------------------------------------------------------------------
  // classification
  // ----------------------------------------------------------------------

  logic is_irq;
  logic retire;
  logic trap_ex;
  logic trap_irq;

  // top bit of the cause tells interrupts from synchronous exceptions
  assign is_irq   = commit_instr_i.cause.fields.irq;
  assign retire   = commit_ack_i & ~commit_instr_i.ex_valid;
  assign trap_ex  = commit_ack_i & commit_instr_i.ex_valid & ~is_irq;
  assign trap_irq = commit_ack_i & commit_instr_i.ex_valid & is_irq;

  always_comb begin
    trace_o.valid     = retire;
    trace_o.insn      = commit_instr_i.tval[31:0];
    trace_o.iaddr     = commit_instr_i.pc;
    trace_o.priv      = priv_lvl_i;
    trace_o.exception = trap_ex;
    trace_o.interrupt = trap_irq;
    trace_o.cause     = commit_instr_i.cause;
    trace_o.tval      = commit_instr_i.tval;
  end

  // ----------------------------------------------------------------------
  // retired pc queue
  // ----------------------------------------------------------------------

  commit_trace_pkg::pc_t mem_q [Depth];

  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic [CntWidth-1:0] count_d;
  logic                empty;
  logic                full;
  logic                push;
  logic                pop;
  logic                drop;
  logic                overflow_q;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count_q == '0);
  assign full  = (count_q == CntWidth'(Depth));

  // a pop on an empty queue is ignored
  assign pop  = pop_i & ~empty;

  // a full queue still accepts when its head leaves in the same cycle
  assign push = retire & (~full | pop);
  assign drop = retire & full & ~pop;

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 1'b1;
    end else if (pop && !push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      count_q <= count_d;
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // sticky until reset
      if (drop) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= commit_instr_i.pc;
    end
  end

  // ----------------------------------------------------------------------
  // outputs to the merge
  // ----------------------------------------------------------------------

  assign pc_avail_o = ~empty;
  assign pc_head_o  = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

/* hw/retire_pc_merge.sv */
`timescale 1ns/1ps
`include "commit_trace_settings.svh"

module retire_pc_merge (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                  [`CT_NR_COMMIT_PORTS-1:0]  pc_avail_i,
  input  commit_trace_pkg::pc_t [`CT_NR_COMMIT_PORTS-1:0]  pc_head_i,
  output logic                  [`CT_NR_COMMIT_PORTS-1:0]  pop_o,
  output logic                                              pc_valid_o,
  output commit_trace_pkg::merged_pc_t                      pc_o
);

  localparam int unsigned PortWidth = $clog2(`CT_NR_COMMIT_PORTS);

  logic [PortWidth-1:0]         last_q;
  logic [PortWidth-1:0]         sel;
  logic                         any_avail;
  logic                         pc_valid_q;
  commit_trace_pkg::merged_pc_t pc_q;

  // ----------------------------------------------------------------------
  // round robin between the two queues
  // ----------------------------------------------------------------------

  assign any_avail = |pc_avail_i;

  // contention goes to the port not granted last time
  always_comb begin
    if (pc_avail_i[0] && pc_avail_i[1]) begin
      sel = ~last_q;
    end else if (pc_avail_i[1]) begin
      sel = PortWidth'(1);
    end else begin
      sel = '0;
    end
  end

  // exactly one head leaves per cycle while anything is queued
  always_comb begin
    for (int i = 0; i < `CT_NR_COMMIT_PORTS; i++) begin
      pop_o[i] = any_avail & (sel == PortWidth'(i));
    end
  end

  // ----------------------------------------------------------------------
  // grant pointer and output stage
  // ----------------------------------------------------------------------

  // pointer starts on port 1, so port 0 wins the first tie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q     <= PortWidth'(1);
      pc_valid_q <= 1'b0;
      pc_q       <= '0;
    end else begin
      pc_valid_q <= any_avail;
      if (any_avail) begin
        last_q    <= sel;
        pc_q.pc   <= pc_head_i[sel];
        pc_q.port <= sel;
      end
    end
  end

  // no back-pressure, the stream is consumed every cycle
  assign pc_valid_o = pc_valid_q;
  assign pc_o       = pc_q;

endmodule

/* hw/commit_trace.sv */
`timescale 1ns/1ps
`include "commit_trace_settings.svh"

module commit_trace (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                            [`CT_NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  commit_trace_pkg::commit_entry_t [`CT_NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  commit_trace_pkg::priv_lvl_t                           priv_lvl_i,
  output commit_trace_pkg::trace_port_t   [`CT_NR_COMMIT_PORTS-1:0] trace_o,
  output logic                                                  pc_valid_o,
  output commit_trace_pkg::merged_pc_t                          pc_o,
  output logic                            [`CT_NR_COMMIT_PORTS-1:0] overflow_o
);

  // queue status towards the merge
  logic                  [`CT_NR_COMMIT_PORTS-1:0] pc_avail;
  commit_trace_pkg::pc_t [`CT_NR_COMMIT_PORTS-1:0] pc_head;
  logic                  [`CT_NR_COMMIT_PORTS-1:0] pc_pop;

  // ----------------------------------------------------------------------
  // per-port trace and queue
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < `CT_NR_COMMIT_PORTS; i++) begin : gen_port
    commit_port_tracer #(
      .Depth ( `CT_PC_QUEUE_DEPTH )
    ) i_tracer (
      .clk_i          ( clk_i             ),
      .rst_ni         ( rst_ni            ),
      .commit_ack_i   ( commit_ack_i[i]   ),
      .commit_instr_i ( commit_instr_i[i] ),
      .priv_lvl_i     ( priv_lvl_i        ),
      .pop_i          ( pc_pop[i]         ),
      .trace_o        ( trace_o[i]        ),
      .pc_avail_o     ( pc_avail[i]       ),
      .pc_head_o      ( pc_head[i]        ),
      .overflow_o     ( overflow_o[i]     )
    );
  end

  // ----------------------------------------------------------------------
  // merged retire stream
  // ----------------------------------------------------------------------

  retire_pc_merge i_merge (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .pc_avail_i ( pc_avail   ),
    .pc_head_i  ( pc_head    ),
    .pop_o      ( pc_pop     ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       )
  );

endmodule

/* dv/commit_trace_assertions.sv */
`timescale 1ns/1ps
`include "commit_trace_settings.svh"

module commit_trace_assertions (
  input logic                                                clk_i,
  input logic                                                rst_ni,
  input logic                                                pc_valid_o,
  input logic                          [`CT_NR_COMMIT_PORTS-1:0] overflow_o,
  input commit_trace_pkg::trace_port_t [`CT_NR_COMMIT_PORTS-1:0] trace_o
);

  // merged stream stays quiet in the first cycle out of reset
  a_valid_low_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |=> !pc_valid_o
  ) else $error("pc_valid_o high in the first cycle after reset");

  for (genvar i = 0; i < `CT_NR_COMMIT_PORTS; i++) begin : gen_port_checks
    // overflow is sticky
    a_overflow_sticky: assert property (
      @(posedge clk_i) disable iff (!rst_ni) !$fell(overflow_o[i])
    ) else $error("overflow_o[%0d] cleared while out of reset", i);

    // a committed entry is a retire, an exception or an interrupt, never two
    a_strobes_exclusive: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({trace_o[i].valid, trace_o[i].exception, trace_o[i].interrupt})
    ) else $error("trace_o[%0d] has more than one strobe set", i);
  end

endmodule

bind commit_trace commit_trace_assertions i_assertions (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .pc_valid_o ( pc_valid_o ),
  .overflow_o ( overflow_o ),
  .trace_o    ( trace_o    )
);

/* dv/commit_trace_tb.sv */
`timescale 1ns/1ps
`include "commit_trace_settings.svh"

module commit_trace_tb;

  localparam int NrPorts   = `CT_NR_COMMIT_PORTS;
  localparam int Depth     = `CT_PC_QUEUE_DEPTH;
  localparam int MaxCycles = 2000;

  logic                                           clk_i;
  logic                                           rst_ni;
  logic                            [NrPorts-1:0] commit_ack_i;
  commit_trace_pkg::commit_entry_t [NrPorts-1:0] commit_instr_i;
  commit_trace_pkg::priv_lvl_t                   priv_lvl_i;
  commit_trace_pkg::trace_port_t   [NrPorts-1:0] trace_o;
  logic                                          pc_valid_o;
  commit_trace_pkg::merged_pc_t                  pc_o;
  logic                            [NrPorts-1:0] overflow_o;

  // reference model state
  commit_trace_pkg::pc_t        model_q [NrPorts][$];
  logic                         model_last;
  logic                         exp_valid;
  commit_trace_pkg::merged_pc_t exp_pc;
  logic           [NrPorts-1:0] exp_overflow;
  int                           fail_count;
  int                           cycle_count;

  commit_trace dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_instr_i ( commit_instr_i ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .trace_o        ( trace_o        ),
    .pc_valid_o     ( pc_valid_o     ),
    .pc_o           ( pc_o           ),
    .overflow_o     ( overflow_o     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // failure handling and compare tasks
  // ----------------------------------------------------------------------

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_trace(string name, commit_trace_pkg::trace_port_t got,
                             commit_trace_pkg::trace_port_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("Fail time=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pc(string name, commit_trace_pkg::merged_pc_t got,
                          commit_trace_pkg::merged_pc_t exp);
    if (got !== exp) begin
      fail_count++;
      $display("Fail time=%0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_count++;
      $display("Fail time=%0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      abort_run();
    end
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  // cause msb separates interrupts from synchronous exceptions
  function automatic commit_trace_pkg::trace_port_t expected_trace(
      logic ack, commit_trace_pkg::commit_entry_t e, commit_trace_pkg::priv_lvl_t priv);
    commit_trace_pkg::trace_port_t t;
    logic                          irq;
    irq         = e.cause.raw[`CT_XLEN-1];
    t.valid     = ack & ~e.ex_valid;
    t.insn      = e.tval[31:0];
    t.iaddr     = e.pc;
    t.priv      = priv;
    t.exception = ack & e.ex_valid & ~irq;
    t.interrupt = ack & e.ex_valid & irq;
    t.cause     = e.cause;
    t.tval      = e.tval;
    return t;
  endfunction

  task automatic reset_model();
    for (int p = 0; p < NrPorts; p++) begin
      model_q[p].delete();
    end
    model_last   = 1'b1;
    exp_valid    = 1'b0;
    exp_pc       = '0;
    exp_overflow = '0;
  endtask

  // one clock edge of queues and merge, from the inputs it will sample
  task automatic advance_model();
    logic [NrPorts-1:0] avail;
    logic [NrPorts-1:0] full;
    logic [NrPorts-1:0] popped;
    logic               sel;
    logic               retire;
    for (int p = 0; p < NrPorts; p++) begin
      avail[p] = (model_q[p].size() != 0);
      full[p]  = (model_q[p].size() == Depth);
    end
    popped = '0;
    if (avail[0] && avail[1]) begin
      sel = ~model_last;
    end else begin
      sel = avail[1];
    end
    exp_valid = |avail;
    if (|avail) begin
      exp_pc.pc   = model_q[sel].pop_front();
      exp_pc.port = sel;
      popped[sel] = 1'b1;
      model_last  = sel;
    end
    for (int p = 0; p < NrPorts; p++) begin
      retire = commit_ack_i[p] & ~commit_instr_i[p].ex_valid;
      if (retire && (!full[p] || popped[p])) begin
        model_q[p].push_back(commit_instr_i[p].pc);
      end else if (retire) begin
        exp_overflow[p] = 1'b1;
      end
    end
  endtask

  task automatic compare_outputs();
    for (int p = 0; p < NrPorts; p++) begin
      check_trace($sformatf("trace_o[%0d]", p), trace_o[p],
                  expected_trace(commit_ack_i[p], commit_instr_i[p], priv_lvl_i));
      check_flag($sformatf("overflow_o[%0d]", p), overflow_o[p], exp_overflow[p]);
    end
    check_flag("pc_valid_o", pc_valid_o, exp_valid);
    if (exp_valid) begin
      check_pc("pc_o", pc_o, exp_pc);
    end
  endtask

  initial begin : compare_proc
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      compare_outputs();
      advance_model();
    end
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------

  function automatic commit_trace_pkg::commit_entry_t make_entry(
      commit_trace_pkg::pc_t pc, logic ex, logic irq);
    commit_trace_pkg::commit_entry_t e;
    e.pc        = pc;
    e.ex_valid  = ex;
    e.cause.raw = {irq, 31'($urandom()), $urandom()};
    e.tval      = {$urandom(), $urandom()};
    return e;
  endfunction

  function automatic commit_trace_pkg::priv_lvl_t random_priv();
    case ($urandom_range(2))
      0:       return commit_trace_pkg::PRIV_LVL_U;
      1:       return commit_trace_pkg::PRIV_LVL_S;
      default: return commit_trace_pkg::PRIV_LVL_M;
    endcase
  endfunction

  task automatic step_inputs(logic [NrPorts-1:0] ack, commit_trace_pkg::commit_entry_t e0,
                             commit_trace_pkg::commit_entry_t e1,
                             commit_trace_pkg::priv_lvl_t priv);
    @(posedge clk_i);
    #1;
    commit_ack_i      = ack;
    commit_instr_i[0] = e0;
    commit_instr_i[1] = e1;
    priv_lvl_i        = priv;
  endtask

  task automatic step_idle();
    step_inputs('0, '0, '0, commit_trace_pkg::PRIV_LVL_M);
  endtask

  task automatic wait_drained();
    while (model_q[0].size() != 0 || model_q[1].size() != 0 || exp_valid) begin
      step_idle();
    end
    step_idle();
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial begin : main_proc
    logic                 [NrPorts-1:0] ack;
    logic                 [NrPorts-1:0] ex;
    commit_trace_pkg::commit_entry_t    e [NrPorts];
    commit_trace_pkg::merged_pc_t       first;
    void'($urandom(73));
    fail_count     = 0;
    cycle_count    = 0;
    rst_ni         = 1'b0;
    commit_ack_i   = '0;
    commit_instr_i = '0;
    priv_lvl_i     = commit_trace_pkg::PRIV_LVL_M;
    reset_model();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // double retires right after reset, port 0 wins the first tie
    for (int k = 0; k < 6; k++) begin
      step_inputs(2'b11, make_entry(40'h1000 + 4 * k, 1'b0, 1'b0),
                  make_entry(40'h2000 + 4 * k, 1'b0, 1'b0), commit_trace_pkg::PRIV_LVL_M);
      if (k == 2) begin
        first.pc   = 40'h1000;
        first.port = 1'b0;
        check_flag("pc_valid_o", pc_valid_o, 1'b1);
        check_pc("pc_o", pc_o, first);
      end
    end
    wait_drained();

    // single retire into empty queues, out one cycle after the push edge
    step_inputs(2'b01, make_entry(40'h3000, 1'b0, 1'b0), '0, commit_trace_pkg::PRIV_LVL_S);
    step_idle();
    @(negedge clk_i);
    check_flag("pc_valid_o", pc_valid_o, 1'b0);
    @(negedge clk_i);
    first.pc   = 40'h3000;
    first.port = 1'b0;
    check_flag("pc_valid_o", pc_valid_o, 1'b1);
    check_pc("pc_o", pc_o, first);
    wait_drained();

    // traps mixed with retires, only retires reach the stream
    for (int k = 0; k < 30; k++) begin
      for (int p = 0; p < NrPorts; p++) begin
        ack[p] = 1'b1;
        ex[p]  = ($urandom_range(1) == 0);
        e[p]   = make_entry(40'h4000 + 40'h100 * p + 4 * k, ex[p], $urandom_range(1));
      end
      step_inputs(ack, e[0], e[1], commit_trace_pkg::PRIV_LVL_M);
    end
    wait_drained();

    // random acks, exceptions, causes and privilege
    for (int k = 0; k < 200; k++) begin
      for (int p = 0; p < NrPorts; p++) begin
        ack[p] = $urandom_range(1);
        ex[p]  = ($urandom_range(3) == 0);
        e[p]   = make_entry(commit_trace_pkg::pc_t'({$urandom(), $urandom()}), ex[p],
                            $urandom_range(1));
      end
      step_inputs(ack, e[0], e[1], random_priv());
    end
    wait_drained();

    // sustained double retires overrun both queues
    for (int k = 0; k < 40; k++) begin
      step_inputs(2'b11, make_entry(40'h8000 + 4 * k, 1'b0, 1'b0),
                  make_entry(40'h9000 + 4 * k, 1'b0, 1'b0), commit_trace_pkg::PRIV_LVL_U);
    end
    wait_drained();
    @(negedge clk_i);
    check_flag("overflow_o[0]", overflow_o[0], 1'b1);
    check_flag("overflow_o[1]", overflow_o[1], 1'b1);

    if (fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* commit_trace.f */
+incdir+hw
hw/commit_trace_pkg.sv
hw/commit_port_tracer.sv
hw/retire_pc_merge.sv
hw/commit_trace.sv
dv/commit_trace_assertions.sv
dv/commit_trace_tb.sv
